//--- design/femtoPkg.sv
// Shared types and constants of the femto RV32I core
// Word and index types, decoded instruction classes, sequencer states
// and the major-opcode values of the base instruction set
`default_nettype none

package femtoPkg;

   // Data, instruction and address words
   typedef logic [31:0] wordT;
   // Register index and shift amount
   typedef logic [4:0] regIdT;
   typedef logic [4:0] shamtT;
   // Function field of the instruction
   typedef logic [2:0] funct3T;

   // One value per decoded instruction class
   // SYSTEM and unknown opcodes fall into classOther
   typedef enum logic [3:0] {
      classLoad,
      classAluImm,
      classAuipc,
      classStore,
      classAluReg,
      classLui,
      classBranch,
      classJalr,
      classJal,
      classOther
   } instrClassT;

   // Sequencer states, one-hot
   typedef enum logic [3:0] {
      stateFetch      = 4'b0001,
      stateWaitInstr  = 4'b0010,
      stateExecute    = 4'b0100,
      stateWaitAluMem = 4'b1000
   } coreStateT;

   // Major opcode, instruction bits 6..2
   localparam logic [4:0] opLoad   = 5'b00000;
   localparam logic [4:0] opAluImm = 5'b00100;
   localparam logic [4:0] opAuipc  = 5'b00101;
   localparam logic [4:0] opStore  = 5'b01000;
   localparam logic [4:0] opAluReg = 5'b01100;
   localparam logic [4:0] opLui    = 5'b01101;
   localparam logic [4:0] opBranch = 5'b11000;
   localparam logic [4:0] opJalr   = 5'b11001;
   localparam logic [4:0] opJal    = 5'b11011;
   // Ignored by the core, no write-back
   localparam logic [4:0] opSystem = 5'b11100;

endpackage

`default_nettype wire

//--- design/decodedInstrIf.sv
// Decoded instruction bundle
// Carries class, function field, destination and immediates
// from the decoder to the ALU and the sequencer
`timescale 1ns/1ns
`default_nettype none

interface decodedInstrIf;

   femtoPkg::instrClassT instrClass;
   femtoPkg::funct3T     funct3;
   // Subtract for ADD/SUB, arithmetic for right shifts
   logic                 altOp;
   femtoPkg::regIdT      rdId;
   // Sign-extended immediates, all five formats
   femtoPkg::wordT       iImm;
   femtoPkg::wordT       sImm;
   femtoPkg::wordT       bImm;
   femtoPkg::wordT       jImm;
   femtoPkg::wordT       uImm;

   // Decoder side
   modport producer (output instrClass, funct3, altOp, rdId, iImm, sImm, bImm, jImm, uImm);
   // ALU and sequencer side
   modport consumer (input instrClass, funct3, altOp, rdId, iImm, sImm, bImm, jImm, uImm);

endinterface

`default_nettype wire

//--- design/instrDecoder.sv
// Instruction decoder
// Latches the fetched word and splits it into class, register
// indices, function field and the five immediate formats
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
   input  logic                   clk,
   input  logic                   instrLatch,
   input  femtoPkg::wordT         memRdata,
   output femtoPkg::regIdT        rs1Id,
   output femtoPkg::regIdT        rs2Id,
   decodedInstrIf.producer        dec
);

   // Bits 1..0 are always 11 in RV32I, not kept
   logic [31:2] instr;

   always_ff @(posedge clk) begin
      if (instrLatch) begin
         instr <= memRdata[31:2];
      end
   end

   // Source indices come straight from the bus
   // so the register file reads them in the latch cycle
   assign rs1Id = memRdata[19:15];
   assign rs2Id = memRdata[24:20];

   assign dec.rdId   = instr[11:7];
   assign dec.funct3 = instr[14:12];

   // Bit 30 set means SUB for register ops, SRA/SRAI for right shifts
   // ADDI reuses bit 30 as immediate, hence the bit 5 check
   assign dec.altOp = instr[30] & (instr[5] | (instr[14:12] == 3'b101));

   // Immediate formats
   assign dec.uImm = {instr[31:12], 12'b0};
   assign dec.iImm = {{21{instr[31]}}, instr[30:20]};
   assign dec.sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign dec.bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign dec.jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // Major opcode to class
   always_comb begin
      case (instr[6:2])
         femtoPkg::opLoad: begin
            dec.instrClass = femtoPkg::classLoad;
         end
         femtoPkg::opAluImm: begin
            dec.instrClass = femtoPkg::classAluImm;
         end
         femtoPkg::opAuipc: begin
            dec.instrClass = femtoPkg::classAuipc;
         end
         femtoPkg::opStore: begin
            dec.instrClass = femtoPkg::classStore;
         end
         femtoPkg::opAluReg: begin
            dec.instrClass = femtoPkg::classAluReg;
         end
         femtoPkg::opLui: begin
            dec.instrClass = femtoPkg::classLui;
         end
         femtoPkg::opBranch: begin
            dec.instrClass = femtoPkg::classBranch;
         end
         femtoPkg::opJalr: begin
            dec.instrClass = femtoPkg::classJalr;
         end
         femtoPkg::opJal: begin
            dec.instrClass = femtoPkg::classJal;
         end
         // SYSTEM and anything unknown
         default: begin
            dec.instrClass = femtoPkg::classOther;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- design/regFile.sv
// Integer register file
// Thirty-two words, x0 reads zero, operands captured when the
// instruction is latched, one write-back port
`timescale 1ns/1ns
`default_nettype none

module regFile (
   input  logic            clk,
   input  logic            reset,
   input  logic            instrLatch,
   input  femtoPkg::regIdT rs1Id,
   input  femtoPkg::regIdT rs2Id,
   input  femtoPkg::regIdT rdId,
   input  logic            writeBack,
   input  femtoPkg::wordT  writeData,
   output femtoPkg::wordT  rs1,
   output femtoPkg::wordT  rs2
);

   femtoPkg::wordT regs [32];

   // Write port, x0 never written
   always_ff @(posedge clk) begin
      if (!reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (writeBack && (rdId != '0)) begin
         regs[rdId] <= writeData;
      end
   end

   // Operand registers
   // No write-back happens in the latch cycle
   always_ff @(posedge clk) begin
      if (instrLatch) begin
         rs1 <= regs[rs1Id];
         rs2 <= regs[rs2Id];
      end
   end

endmodule

`default_nettype wire

//--- design/aluUnit.sv
// Integer ALU
// Add, subtract, compares and logic ops in one cycle
// Shifts run one bit per cycle in a local shift register
// Also produces the conditional branch predicate
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
   input  logic           clk,
   input  logic           reset,
   decodedInstrIf.consumer dec,
   input  femtoPkg::wordT rs1,
   input  femtoPkg::wordT rs2,
   input  logic           aluStart,
   output femtoPkg::wordT aluOut,
   output femtoPkg::wordT aluPlus,
   output logic           predicate,
   output logic           aluBusy
);

   femtoPkg::wordT  aluIn2;
   femtoPkg::wordT  aluReg;
   femtoPkg::shamtT aluShamt;
   logic [32:0]     aluMinus;
   logic            lt;
   logic            ltu;
   logic            eq;
   logic            isShift;

   // Register ops and branches compare rs2
   // Immediate ops, loads and JALR take the I immediate
   assign aluIn2 = ((dec.instrClass == femtoPkg::classAluReg) ||
                    (dec.instrClass == femtoPkg::classBranch)) ? rs2 : dec.iImm;

   // Shared with the JALR target
   assign aluPlus = rs1 + aluIn2;

   // One 33-bit subtract for SUB and every compare
   assign aluMinus = {1'b0, rs1} - {1'b0, aluIn2};
   assign ltu      = aluMinus[32];
   // Signs differ, the negative one is smaller
   assign lt       = (rs1[31] ^ aluIn2[31]) ? rs1[31] : aluMinus[32];
   assign eq       = (aluMinus[31:0] == 32'b0);

   // SLL is 001, SRL/SRA is 101
   assign isShift = (dec.funct3[1:0] == 2'b01);

   always_comb begin
      case (dec.funct3)
         3'b000:  aluOut = dec.altOp ? aluMinus[31:0] : aluPlus;
         3'b010:  aluOut = {31'b0, lt};
         3'b011:  aluOut = {31'b0, ltu};
         3'b100:  aluOut = rs1 ^ aluIn2;
         3'b110:  aluOut = rs1 | aluIn2;
         3'b111:  aluOut = rs1 & aluIn2;
         // Shift result once the count is done
         default: aluOut = aluReg;
      endcase
   end

   // Busy while bits remain to shift
   assign aluBusy = (aluShamt != '0);

   // Remaining shift count
   always_ff @(posedge clk) begin
      if (!reset) begin
         aluShamt <= '0;
      end else if (aluStart && isShift) begin
         aluShamt <= aluIn2[4:0];
      end else if (aluBusy) begin
         aluShamt <= aluShamt - femtoPkg::shamtT'(1);
      end
   end

   // Shift register, left for SLL, right with optional sign fill
   always_ff @(posedge clk) begin
      if (aluStart && isShift) begin
         aluReg <= rs1;
      end else if (aluBusy) begin
         if (dec.funct3 == 3'b001) begin
            aluReg <= {aluReg[30:0], 1'b0};
         end else begin
            aluReg <= {dec.altOp & aluReg[31], aluReg[31:1]};
         end
      end
   end

   // Branch conditions, funct3 010 and 011 never taken
   always_comb begin
      case (dec.funct3)
         3'b000:  predicate = eq;
         3'b001:  predicate = !eq;
         3'b100:  predicate = lt;
         3'b101:  predicate = !lt;
         3'b110:  predicate = ltu;
         3'b111:  predicate = !ltu;
         default: predicate = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- design/coreControl.sv
// Core sequencer
// Four-state fetch/execute FSM, program counter, branch targets,
// load/store address and write-back data selection
// Drives the shared memory port with strobe/busy handshake
`timescale 1ns/1ns
`default_nettype none

module coreControl #(
   parameter femtoPkg::wordT resetAddr = 32'h0000_0000,
   parameter int             addrWidth = 24
) (
   input  logic            clk,
   input  logic            reset,
   decodedInstrIf.consumer dec,
   input  femtoPkg::wordT  rs1,
   input  femtoPkg::wordT  rs2,
   input  femtoPkg::wordT  aluOut,
   input  femtoPkg::wordT  aluPlus,
   input  logic            predicate,
   input  logic            aluBusy,
   input  femtoPkg::wordT  memRdata,
   input  logic            memRbusy,
   input  logic            memWbusy,
   output logic            instrLatch,
   output logic            aluStart,
   output logic            writeBack,
   output femtoPkg::wordT  writeData,
   output femtoPkg::wordT  memAddr,
   output femtoPkg::wordT  memWdata,
   output logic [3:0]      memWmask,
   output logic            memRstrb
);

   femtoPkg::coreStateT  state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcPlusImm;
   logic [addrWidth-1:0] lsAddr;
   logic                 isLoad;
   logic                 isStore;
   logic                 isAlu;
   logic                 isShift;
   logic                 writesRd;
   logic                 needToWait;
   // Set when the wait state must write its result
   logic                 waitWb;

   assign isLoad  = (dec.instrClass == femtoPkg::classLoad);
   assign isStore = (dec.instrClass == femtoPkg::classStore);
   assign isAlu   = (dec.instrClass == femtoPkg::classAluImm) ||
                    (dec.instrClass == femtoPkg::classAluReg);
   assign isShift = isAlu && (dec.funct3[1:0] == 2'b01);

   // Branch, store and SYSTEM leave the registers alone
   assign writesRd = !isStore &&
                     (dec.instrClass != femtoPkg::classBranch) &&
                     (dec.instrClass != femtoPkg::classOther);

   // Memory access or serial shift
   assign needToWait = isLoad || isStore || isShift;

   assign pcPlus4 = pc + addrWidth'(4);

   // One adder for JAL, AUIPC and branch targets
   always_comb begin
      if (dec.instrClass == femtoPkg::classJal) begin
         pcPlusImm = pc + dec.jImm[addrWidth-1:0];
      end else if (dec.instrClass == femtoPkg::classAuipc) begin
         pcPlusImm = pc + dec.uImm[addrWidth-1:0];
      end else begin
         pcPlusImm = pc + dec.bImm[addrWidth-1:0];
      end
   end

   // Separate adder for load/store address
   assign lsAddr = rs1[addrWidth-1:0] +
                   (isStore ? dec.sImm[addrWidth-1:0] : dec.iImm[addrWidth-1:0]);

   // PC while fetching, data address otherwise, upper bits zero
   assign memAddr = femtoPkg::wordT'(((state == femtoPkg::stateFetch) ||
                                      (state == femtoPkg::stateWaitInstr)) ? pc : lsAddr);

   // Word stores only
   assign memWdata = rs2;
   assign memWmask = {4{(state == femtoPkg::stateExecute) && isStore}};

   // Instruction fetch or load request
   assign memRstrb = (state == femtoPkg::stateFetch) ||
                     ((state == femtoPkg::stateExecute) && isLoad);

   assign instrLatch = (state == femtoPkg::stateWaitInstr) && !memRbusy;
   assign aluStart   = (state == femtoPkg::stateExecute) && isAlu;

   // Single-cycle results in execute, loads and shifts while waiting
   assign writeBack = ((state == femtoPkg::stateExecute) && writesRd && !needToWait) ||
                      ((state == femtoPkg::stateWaitAluMem) && waitWb);

   always_comb begin
      case (dec.instrClass)
         femtoPkg::classLui:    writeData = dec.uImm;
         femtoPkg::classAluImm: writeData = aluOut;
         femtoPkg::classAluReg: writeData = aluOut;
         femtoPkg::classAuipc:  writeData = femtoPkg::wordT'(pcPlusImm);
         // Link address
         femtoPkg::classJal:    writeData = femtoPkg::wordT'(pcPlus4);
         femtoPkg::classJalr:   writeData = femtoPkg::wordT'(pcPlus4);
         femtoPkg::classLoad:   writeData = memRdata;
         default:               writeData = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Sit in wait until the memory is idle
         state  <= femtoPkg::stateWaitAluMem;
         pc     <= resetAddr[addrWidth-1:0];
         waitWb <= 1'b0;
      end else begin
         case (state)
            femtoPkg::stateFetch: begin
               state <= femtoPkg::stateWaitInstr;
            end
            femtoPkg::stateWaitInstr: begin
               if (!memRbusy) begin
                  state <= femtoPkg::stateExecute;
               end
            end
            femtoPkg::stateExecute: begin
               // JALR target has bit 0 cleared
               if (dec.instrClass == femtoPkg::classJalr) begin
                  pc <= {aluPlus[addrWidth-1:1], 1'b0};
               end else if ((dec.instrClass == femtoPkg::classJal) ||
                            ((dec.instrClass == femtoPkg::classBranch) && predicate)) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               waitWb <= isLoad || isShift;
               state  <= needToWait ? femtoPkg::stateWaitAluMem : femtoPkg::stateFetch;
            end
            default: begin
               // Shift done and memory idle
               if (!aluBusy && !memRbusy && !memWbusy) begin
                  state <= femtoPkg::stateFetch;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/femtoCore.sv
// Multi-cycle RV32I core, top level
// Decoder, register file, ALU and sequencer around one shared
// word-wide memory port with read and write busy stalls
`timescale 1ns/1ns
`default_nettype none

module femtoCore #(
   parameter femtoPkg::wordT resetAddr = 32'h0000_0000,
   parameter int             addrWidth = 24
) (
   input  logic           clk,
   input  logic           reset,
   output femtoPkg::wordT memAddr,
   output femtoPkg::wordT memWdata,
   output logic [3:0]     memWmask,
   output logic           memRstrb,
   input  femtoPkg::wordT memRdata,
   input  logic           memRbusy,
   input  logic           memWbusy
);

   femtoPkg::regIdT rs1Id;
   femtoPkg::regIdT rs2Id;
   femtoPkg::wordT  rs1;
   femtoPkg::wordT  rs2;
   femtoPkg::wordT  aluOut;
   femtoPkg::wordT  aluPlus;
   femtoPkg::wordT  writeData;
   logic            predicate;
   logic            aluBusy;
   logic            aluStart;
   logic            instrLatch;
   logic            writeBack;

   // Decoded fields shared by ALU and sequencer
   decodedInstrIf decBus ();

   instrDecoder i_instrDecoder (
      .clk        (clk),
      .instrLatch (instrLatch),
      .memRdata   (memRdata),
      .rs1Id      (rs1Id),
      .rs2Id      (rs2Id),
      .dec        (decBus.producer)
   );

   regFile i_regFile (
      .clk        (clk),
      .reset      (reset),
      .instrLatch (instrLatch),
      .rs1Id      (rs1Id),
      .rs2Id      (rs2Id),
      .rdId       (decBus.rdId),
      .writeBack  (writeBack),
      .writeData  (writeData),
      .rs1        (rs1),
      .rs2        (rs2)
   );

   aluUnit i_aluUnit (
      .clk       (clk),
      .reset     (reset),
      .dec       (decBus.consumer),
      .rs1       (rs1),
      .rs2       (rs2),
      .aluStart  (aluStart),
      .aluOut    (aluOut),
      .aluPlus   (aluPlus),
      .predicate (predicate),
      .aluBusy   (aluBusy)
   );

   coreControl #(
      .resetAddr (resetAddr),
      .addrWidth (addrWidth)
   ) i_coreControl (
      .clk        (clk),
      .reset      (reset),
      .dec        (decBus.consumer),
      .rs1        (rs1),
      .rs2        (rs2),
      .aluOut     (aluOut),
      .aluPlus    (aluPlus),
      .predicate  (predicate),
      .aluBusy    (aluBusy),
      .memRdata   (memRdata),
      .memRbusy   (memRbusy),
      .memWbusy   (memWbusy),
      .instrLatch (instrLatch),
      .aluStart   (aluStart),
      .writeBack  (writeBack),
      .writeData  (writeData),
      .memAddr    (memAddr),
      .memWdata   (memWdata),
      .memWmask   (memWmask),
      .memRstrb   (memRstrb)
   );

endmodule

`default_nettype wire

//--- verif/femtoCore_props.sv
// Memory port and sequencer properties of the femto core
// Bound into femtoCore
`timescale 1ns/1ns
`default_nettype none

module femtoCore_props (
   input logic       clk,
   input logic       reset,
   input logic       memRstrb,
   input logic [3:0] memWmask
);

   // Read strobe and store never share a cycle
   strobeVsStore: assert property (@(posedge clk) disable iff (!reset)
      !(memRstrb && (memWmask != 4'h0)))
      else $error("read strobe and write mask active together");

   // Word stores only
   fullMask: assert property (@(posedge clk) disable iff (!reset)
      (memWmask == 4'h0) || (memWmask == 4'hF))
      else $error("partial write mask");

   // Quiet port once reset has been seen for a cycle
   quietInReset: assert property (@(posedge clk)
      (!reset && !$past(reset)) |-> (!memRstrb && (memWmask == 4'h0)))
      else $error("memory port active during reset");

   // Fetch and load strobes are single-cycle pulses
   strobePulse: assert property (@(posedge clk) disable iff (!reset)
      memRstrb |=> !memRstrb)
      else $error("read strobe longer than one cycle");

endmodule

bind femtoCore femtoCore_props i_femtoCoreProps (
   .clk      (clk),
   .reset    (reset),
   .memRstrb (memRstrb),
   .memWmask (memWmask)
);

`default_nettype wire

//--- verif/tb_femtoCore.sv
// Testbench for the femto RV32I core
// Builds random programs per instruction mix, runs them on the DUT
// against a memory with random read/write stalls, and compares the
// register dump, data region and fetch trace with an ISA model
`timescale 1ns/1ns
`default_nettype none

module tb_femtoCore;

   localparam femtoPkg::wordT resetAddr = 32'h0000_0100;
   localparam int             addrWidth = 24;
   localparam femtoPkg::wordT addrMask  = 32'h00FF_FFFF;
   // Data region base held in x31
   // Dump area sits 1 KB above it
   localparam femtoPkg::wordT dataBase  = 32'h0000_0800;
   localparam int             limit     = 20000;

   logic           clk;
   logic           reset;
   femtoPkg::wordT memAddr;
   femtoPkg::wordT memWdata;
   logic [3:0]     memWmask;
   logic           memRstrb;
   femtoPkg::wordT memRdata;
   logic           memRbusy;
   logic           memWbusy;

   femtoPkg::wordT mem [1024];
   femtoPkg::wordT modelMem [1024];
   femtoPkg::wordT x [32];
   femtoPkg::wordT fetchQ [$];
   femtoPkg::wordT modelQ [$];
   femtoPkg::wordT loopAddr;
   logic           done;
   int             rbusyLeft;
   int             wbusyLeft;
   int             errors;
   int             checks;
   int             failedTests;
   int             testCount;

   femtoCore #(
      .resetAddr (resetAddr),
      .addrWidth (addrWidth)
   ) i_femtoCore (
      .clk      (clk),
      .reset    (reset),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memWmask (memWmask),
      .memRstrb (memRstrb),
      .memRdata (memRdata),
      .memRbusy (memRbusy),
      .memWbusy (memWbusy)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Result comparisons against the model
   task automatic checkWord(string what, femtoPkg::wordT got, femtoPkg::wordT exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkAddr(string what, femtoPkg::wordT got, femtoPkg::wordT exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s: address %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkLevel(string what, logic got, logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s: level %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic checkMask(string what, logic [3:0] got, logic [3:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s: mask %h, expected %h", $time, what, got, exp);
      end
   endtask

   // RV32I encoders
   function automatic femtoPkg::wordT encR(logic [6:0] f7, femtoPkg::regIdT rs2,
         femtoPkg::regIdT rs1, femtoPkg::funct3T f3, femtoPkg::regIdT rd);
      return {f7, rs2, rs1, f3, rd, femtoPkg::opAluReg, 2'b11};
   endfunction

   function automatic femtoPkg::wordT encI(logic [11:0] imm, femtoPkg::regIdT rs1,
         femtoPkg::funct3T f3, femtoPkg::regIdT rd, logic [4:0] op);
      return {imm, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic femtoPkg::wordT encS(logic [11:0] imm, femtoPkg::regIdT rs2,
         femtoPkg::regIdT rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], femtoPkg::opStore, 2'b11};
   endfunction

   function automatic femtoPkg::wordT encB(logic [12:0] off, femtoPkg::funct3T f3,
         femtoPkg::regIdT rs1, femtoPkg::regIdT rs2);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], femtoPkg::opBranch, 2'b11};
   endfunction

   function automatic femtoPkg::wordT encJ(logic [20:0] off, femtoPkg::regIdT rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, femtoPkg::opJal, 2'b11};
   endfunction

   // Random register or immediate ALU op
   // Shift ops only when shiftOnly is set
   function automatic femtoPkg::wordT randomAlu(logic shiftOnly);
      femtoPkg::funct3T f3;
      femtoPkg::regIdT  rd;
      femtoPkg::shamtT  shamt;
      logic             alt;
      logic [11:0]      imm;
      f3    = shiftOnly ? (($urandom % 2) != 0 ? 3'b001 : 3'b101) : femtoPkg::funct3T'($urandom);
      rd    = femtoPkg::regIdT'($urandom_range(0, 30));
      shamt = femtoPkg::shamtT'($urandom);
      alt   = (($urandom % 2) != 0);
      if (($urandom % 2) != 0) begin
         if (f3 == 3'b001) imm = {7'b0, shamt};
         else if (f3 == 3'b101) imm = {1'b0, alt, 5'b0, shamt};
         else imm = 12'($urandom);
         return encI(imm, femtoPkg::regIdT'($urandom), f3, rd, femtoPkg::opAluImm);
      end
      return encR({1'b0, alt && ((f3 == 3'b000) || (f3 == 3'b101)), 5'b0},
                  femtoPkg::regIdT'($urandom), femtoPkg::regIdT'($urandom), f3, rd);
   endfunction

   // One instruction of the given mix
   // idx is the word slot and remain the slots left before the dump
   function automatic femtoPkg::wordT randomInstr(int kind, int idx, int remain);
      femtoPkg::funct3T branchF3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
      femtoPkg::regIdT  rd;
      femtoPkg::wordT   target;
      int               r;
      int               k;
      r  = int'($urandom % 8);
      rd = femtoPkg::regIdT'($urandom_range(0, 30));
      k  = 1 + int'($urandom % ((remain < 6) ? remain : 6));
      target = resetAddr + femtoPkg::wordT'(4 * (idx + k));
      if (kind == 1 && r < 7) return randomAlu(r < 5);
      if (kind == 2 && (r == 3 || r == 4))
         return encB(13'(4 * k), branchF3[$urandom % 6], femtoPkg::regIdT'($urandom),
                     femtoPkg::regIdT'($urandom));
      if (kind == 2 && r == 5) return encJ(21'(4 * k), rd);
      // Absolute target through x0 with bit 0 set at random
      if (kind == 2 && r == 6)
         return encI(target[11:0] | 12'($urandom % 2), 5'd0, 3'b000, rd, femtoPkg::opJalr);
      if (kind == 3 && r >= 5) return {20'($urandom), rd, femtoPkg::opAuipc, 2'b11};
      if (kind == 4 && (r == 3 || r == 4))
         return encI(12'(4 * $urandom_range(0, 255)), 5'd31, 3'b010, rd, femtoPkg::opLoad);
      if (kind == 4 && r >= 5)
         return encS(12'(4 * $urandom_range(0, 255)), femtoPkg::regIdT'($urandom), 5'd31);
      if (kind == 0 && r == 7) return 32'h0000_0073;
      if (r < 3 || (kind == 0 && r < 6)) return randomAlu(1'b0);
      return {20'($urandom), rd, femtoPkg::opLui, 2'b11};
   endfunction

   function automatic femtoPkg::wordT aluRef(femtoPkg::funct3T f3, logic alt,
         femtoPkg::wordT a, femtoPkg::wordT b);
      case (f3)
         3'b000:  return alt ? a - b : a + b;
         3'b001:  return a << b[4:0];
         3'b010:  return {31'b0, $signed(a) < $signed(b)};
         3'b011:  return {31'b0, a < b};
         3'b100:  return a ^ b;
         3'b101:  return alt ? femtoPkg::wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchTaken(femtoPkg::funct3T f3, femtoPkg::wordT a,
         femtoPkg::wordT b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         3'b111:  return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   // ISA model running the image in modelMem until the final loop
   task automatic runModel();
      femtoPkg::wordT pc;
      femtoPkg::wordT ins;
      femtoPkg::wordT a;
      femtoPkg::wordT b;
      femtoPkg::wordT iImm;
      femtoPkg::wordT ea;
      femtoPkg::wordT res;
      logic           wr;
      int             steps;
      pc = resetAddr;
      steps = 0;
      for (int i = 0; i < 32; i++) x[i] = '0;
      while (pc != loopAddr && steps < limit) begin
         modelQ.push_back(pc);
         ins  = modelMem[pc[11:2]];
         a    = x[ins[19:15]];
         b    = x[ins[24:20]];
         iImm = {{20{ins[31]}}, ins[31:20]};
         wr   = 1'b1;
         res  = '0;
         case (ins[6:2])
            femtoPkg::opAluImm: begin
               res = aluRef(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, iImm);
            end
            femtoPkg::opAluReg: res = aluRef(ins[14:12], ins[30], a, b);
            femtoPkg::opLui:    res = {ins[31:12], 12'b0};
            femtoPkg::opAuipc:  res = (pc + {ins[31:12], 12'b0}) & addrMask;
            femtoPkg::opLoad: begin
               ea  = (a + iImm) & addrMask;
               res = modelMem[ea[11:2]];
            end
            femtoPkg::opJal, femtoPkg::opJalr: res = (pc + 4) & addrMask;
            default: wr = 1'b0;
         endcase
         if (ins[6:2] == femtoPkg::opStore) begin
            ea = (a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) & addrMask;
            modelMem[ea[11:2]] = b;
         end
         if (ins[6:2] == femtoPkg::opJal)
            pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         else if (ins[6:2] == femtoPkg::opJalr)
            pc = (a + iImm) & ~32'h1;
         else if (ins[6:2] == femtoPkg::opBranch && branchTaken(ins[14:12], a, b))
            pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         else
            pc = pc + 4;
         pc = pc & addrMask;
         if (wr) x[ins[11:7]] = res;
         x[0] = '0;
         steps++;
      end
      modelQ.push_back(loopAddr);
   endtask

   // Memory model called once per rising edge
   task automatic serviceMemory();
      int n;
      if (memRstrb) begin
         memRdata  <= mem[memAddr[11:2]];
         n         = int'($urandom_range(0, 3));
         rbusyLeft = n;
         memRbusy  <= (n != 0);
         // Only fetches fall below the data region
         if (memAddr < dataBase && !done) begin
            fetchQ.push_back(memAddr);
            done = (memAddr == loopAddr);
         end
      end else if (rbusyLeft > 0) begin
         rbusyLeft--;
         memRbusy <= (rbusyLeft != 0);
      end
      if (memWmask != 4'h0) begin
         mem[memAddr[11:2]] = memWdata;
         n         = int'($urandom_range(0, 3));
         wbusyLeft = n;
         memWbusy  <= (n != 0);
      end else if (wbusyLeft > 0) begin
         wbusyLeft--;
         memWbusy <= (wbusyLeft != 0);
      end
   endtask

   task automatic runTest(string name, int kind, int count);
      int cycles;
      int startErr;
      int startChk;
      int base;
      startErr = errors;
      startChk = checks;
      // Fill pattern over the whole word index
      for (int i = 0; i < 1024; i++) mem[i] = femtoPkg::wordT'(i) * 32'h9E37_79B1 + 32'h1;
      base = int'(resetAddr[11:2]);
      mem[base]     = encI(12'h400, 5'd0, 3'b000, 5'd31, femtoPkg::opAluImm);
      mem[base + 1] = encI(12'h400, 5'd31, 3'b000, 5'd31, femtoPkg::opAluImm);
      for (int i = 0; i < count; i++) mem[base + 2 + i] = randomInstr(kind, 2 + i, count - i);
      for (int i = 0; i < 32; i++)
         mem[base + 2 + count + i] = encS(12'(12'h400 + 4 * i), femtoPkg::regIdT'(i), 5'd31);
      mem[base + 34 + count] = encJ(21'd0, 5'd0);
      loopAddr = resetAddr + femtoPkg::wordT'(4 * (34 + count));
      modelMem = mem;
      modelQ.delete();
      fetchQ.delete();
      runModel();
      @(posedge clk);
      reset    <= 1'b0;
      memRbusy <= 1'b0;
      memWbusy <= 1'b0;
      rbusyLeft = 0;
      wbusyLeft = 0;
      done = 1'b0;
      for (int c = 0; c < 10; c++) begin
         @(posedge clk);
         if (c > 0) begin
            checkLevel("memRstrb in reset", memRstrb, 1'b0);
            checkMask("memWmask in reset", memWmask, 4'h0);
         end
      end
      reset <= 1'b1;
      cycles = 0;
      while (!done && cycles < limit) begin
         @(posedge clk);
         serviceMemory();
         cycles++;
      end
      if (!done) begin
         errors++;
         $display("Timeout in test %s: final loop never fetched after %0d cycles", name, limit);
      end else begin
         checkAddr("first fetch", fetchQ[0], resetAddr);
         if (fetchQ.size() != modelQ.size()) begin
            errors++;
            $display("[FAIL] %0t fetch count %0d, expected %0d", $time, fetchQ.size(),
                     modelQ.size());
         end
         for (int i = 0; i < fetchQ.size() && i < modelQ.size(); i++)
            checkAddr($sformatf("fetch %0d", i), fetchQ[i], modelQ[i]);
         for (int r = 0; r < 32; r++)
            checkWord($sformatf("x%0d", r), mem[768 + r], x[r]);
         for (int i = 512; i < 800; i++)
            checkWord($sformatf("word at %h", 4 * i), mem[i], modelMem[i]);
      end
      testCount++;
      if (errors != startErr) failedTests++;
      $display("test %s %0d checks, %0d errors", name, checks - startChk, errors - startErr);
   endtask

   initial begin
      reset     = 1'b0;
      memRdata  = '0;
      memRbusy  = 1'b0;
      memWbusy  = 1'b0;
      rbusyLeft = 0;
      wbusyLeft = 0;
      done      = 1'b0;
      errors    = 0;
      checks    = 0;
      failedTests = 0;
      testCount = 0;
      void'($urandom(15));
      runTest("reset", 0, 4);
      runTest("alu", 0, 60);
      runTest("shift", 1, 60);
      runTest("flow", 2, 60);
      runTest("upper", 3, 60);
      runTest("memory", 4, 60);
      $display("tests %0d, failing %0d, checks %0d, errors %0d", testCount, failedTests,
               checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
design/femtoPkg.sv
design/decodedInstrIf.sv
design/instrDecoder.sv
design/regFile.sv
design/aluUnit.sv
design/coreControl.sv
design/femtoCore.sv
verif/femtoCore_props.sv
verif/tb_femtoCore.sv

//--- Makefile
SRCS := $(filter-out +%,$(shell cat files.f))

obj_dir/Vtb_femtoCore: files.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_femtoCore -f files.f

run: obj_dir/Vtb_femtoCore
	@out="$$(./obj_dir/Vtb_femtoCore)"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf obj_dir

.PHONY: run clean
